// ==== fpuPipe.f ====
verilog/fpuTypesPkg.sv
verilog/fpuStagePkg.sv
verilog/fpuRegFile.sv
verilog/fpuHazard.sv
verilog/fpuExecute.sv
verilog/fpuPipe.sv
verif/fpuClockGen.sv
verif/fpuPipeTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the FPU pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module fpuPipeTb -f fpuPipe.f -o fpuPipeSim

out=$(./obj_dir/fpuPipeSim)
echo "$out"

# a run without the pass line counts as a failure
echo "$out" | grep -q "TESTS PASSED"

// ==== verif/fpuPipeTb.sv ====
// testbench for the FPU pipeline slice
//   clock and reset, instruction queue driver with acceptance tracking
//   Galois LFSR for random fields, model register file and reference function
//   compare process for retirements, per-cycle stall prediction, watchdog
`timescale 1ns/1ns

module fpuPipeTb;

  import fpuTypesPkg::*;
  import fpuStagePkg::*;

  localparam int ClkPeriod   = 20;
  localparam int ResetCycles = 16;
  localparam int RandLen     = 300;
  localparam int DirectedLen = 100;   // upper bound over tests 1 to 5
  localparam int WatchdogNs  = ((RandLen + DirectedLen) * 40 + ResetCycles) * ClkPeriod;
  localparam logic [31:0] Taps = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

  logic   clk;
  logic   rstN;
  logic   instValid;
  fpInstT inst;
  logic   stallD;
  logic   wbValid;
  fpWbT   wb;

  fpInstT stimQ [$];     // instructions still to present
  fpWbT   expQ [$];      // expected retirements in age order
  int     dueQ [$];      // cycle each expected retirement is due in
  fpDataT modelRegs [32];
  logic [31:0] lfsrState = 32'd39;
  int     cycle = 0;
  int     errors = 0;
  int     checks = 0;
  int     testNum = 0;
  logic   lastWasMadd = 1'b0;   // last accepted instruction
  regAdrT lastRd = '0;
  int     lastAcceptCycle = -10;

  fpuClockGen fpuClockGen_inst (.clk(clk));

  fpuPipe fpuPipe_inst (
    .clk       (clk),
    .rstN      (rstN),
    .instValid (instValid),
    .inst      (inst),
    .stallD    (stallD),
    .wbValid   (wbValid),
    .wb        (wb)
  );

  always @(posedge clk) cycle <= cycle + 1;

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers and reference model
  ////////////////////////////////////////////////////////////////////////////

  // one LFSR step per bit taken with bits shifted in msb first
  function automatic logic [31:0] lfsrBits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      bits = {bits[30:0], lfsrState[0]};
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ Taps) : (lfsrState >> 1);
    end
    return bits;
  endfunction

  task automatic queueInst(input fpOpT op, input int rd, input int rs1, input int rs2,
                           input int rs3, input int imm);
    fpInstT i;
    i.op  = op;
    i.rd  = rd[4:0];
    i.rs1 = rs1[4:0];
    i.rs2 = rs2[4:0];
    i.rs3 = rs3[4:0];
    i.imm = imm[15:0];
    stimQ.push_back(i);
  endtask

  task automatic queueFli(input int rd, input int imm);
    queueInst(OP_FLI, rd, 0, 0, 0, imm);
  endtask

  // sources an op actually reads and none for FLI
  function automatic logic readsReg(input fpInstT i, input regAdrT r);
    case (i.op)
      OP_FADD, OP_FSUB, OP_FMIN: return (i.rs1 == r) || (i.rs2 == r);
      OP_FMADD:                  return (i.rs1 == r) || (i.rs2 == r) || (i.rs3 == r);
      default:                   return 1'b0;
    endcase
  endfunction

  // executes one instruction in program order on the model registers
  function automatic fpWbT refExec(input fpInstT i);
    fpDataT x;
    fpDataT y;
    fpDataT z;
    fpDataT r;
    fpWbT   res;
    x = modelRegs[i.rs1];
    y = modelRegs[i.rs2];
    z = modelRegs[i.rs3];
    case (i.op)
      OP_FLI:  r = int'(signed'(i.imm));        // immediate as a signed value
      OP_FADD: r = x + y;
      OP_FSUB: r = x - y;
      OP_FMIN: r = (int'(x) < int'(y)) ? x : y;  // two's-complement min
      default: r = x * y + z;                    // FMADD keeps the low 32 bits
    endcase
    modelRegs[i.rd] = r;
    res.rd   = i.rd;
    res.data = r;
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkWb(input fpWbT got, input fpWbT exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("FAIL %0t: %s rd %0d data %h, expected rd %0d data %h",
               $time, what, got.rd, got.data, exp.rd, exp.data);
      errors++;
    end
  endtask

  task automatic checkStall(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("FAIL %0t: %s stallD %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // driver
  ////////////////////////////////////////////////////////////////////////////

  // stall stays low with no instruction presented
  task automatic idleCycles(input int n);
    instValid = 1'b0;
    repeat (n) begin
      @(negedge clk);
      checkStall(stallD, 1'b0, "idle");
      @(posedge clk);
      #2;
    end
  endtask

  // present stimQ and advance on acceptance before waiting for all retirements
  task automatic runStream(input string name);
    fpInstT cur;
    logic   expStall;
    int     errStart;
    int     stalls;
    int     count;
    errStart = errors;
    stalls   = 0;
    count    = stimQ.size();
    testNum++;
    while (stimQ.size() > 0) begin
      cur       = stimQ[0];
      inst      = cur;
      instValid = 1'b1;
      @(negedge clk);  // inputs and stage registers settled here
      expStall = lastWasMadd && (lastAcceptCycle == cycle - 1) && readsReg(cur, lastRd);
      checkStall(stallD, expStall, name);
      if (stallD === 1'b1) begin
        stalls++;
      end else begin
        expQ.push_back(refExec(cur));
        dueQ.push_back(cycle + 3);   // decode, execute, memory, then writeback
        lastWasMadd     = (cur.op == OP_FMADD);
        lastRd          = cur.rd;
        lastAcceptCycle = cycle;
        void'(stimQ.pop_front());
      end
      @(posedge clk);
      #2;
    end
    instValid = 1'b0;
    while (expQ.size() > 0) @(posedge clk);
    repeat (2) @(posedge clk);
    #2;
    $display("test %0d %s: %0d instructions, %0d stalls, %s", testNum, name, count,
             stalls, (errors == errStart) ? "ok" : "mismatch");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // processes
  ////////////////////////////////////////////////////////////////////////////

  initial begin : compareProc
    fpWbT expWb;
    int   due;
    forever begin
      @(negedge clk);
      if (rstN === 1'b1) begin
        if (wbValid === 1'b1) begin
          if (expQ.size() == 0) begin
            $display("retirement at %0t ns with no instruction outstanding", $time);
            errors++;
          end else begin
            expWb = expQ.pop_front();
            due   = dueQ.pop_front();
            checkWb(wb, expWb, "retired");
            if (cycle != due) begin
              $display("FAIL %0t: retired in cycle %0d, expected cycle %0d", $time, cycle, due);
              errors++;
            end
          end
        end else if (wbValid !== 1'b0) begin
          $display("wbValid is unknown at %0t ns", $time);
          errors++;
        end
      end
    end
  end

  initial begin : watchdog
    #(WatchdogNs);
    $display("watchdog expired after %0d ns, the run did not complete", WatchdogNs);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : mainProc
    int opIdx;
    fpOpT op;
    rstN      = 1'b0;
    instValid = 1'b0;
    inst      = '0;
    for (int r = 0; r < 32; r++) modelRegs[r] = '0;
    repeat (ResetCycles) @(posedge clk);
    #2;
    rstN = 1'b1;

    // test 1 checks quiet outputs after reset and zero in every register
    idleCycles(8);
    for (int r = 0; r < 32; r++) queueInst(OP_FADD, r, r, r, 0, 0);
    runStream("reset state");

    // test 2 with immediates of both signs and edge values first
    queueFli(1, 0);
    queueFli(2, 1);
    queueFli(3, 'hFFFF);
    queueFli(4, 'h7FFF);
    queueFli(5, 'h8000);
    queueFli(6, 'h1234);
    queueFli(7, 'hABCD);
    queueFli(8, 'h8001);
    for (int r = 9; r < 13; r++) queueFli(r, int'(lfsrBits(16)));
    runStream("fli sign extension");

    // test 3 with ALU chains at distance one, two and three
    queueFli(1, 7);
    queueFli(2, -3);
    queueInst(OP_FADD, 3, 2, 1, 0, 0);   // r2 from memory and r1 from writeback
    queueInst(OP_FSUB, 4, 3, 1, 0, 0);   // r1 through the register file bypass
    queueInst(OP_FMIN, 5, 4, 2, 0, 0);
    queueInst(OP_FADD, 5, 5, 3, 0, 0);
    queueInst(OP_FSUB, 6, 5, 5, 0, 0);
    queueInst(OP_FMIN, 7, 6, 4, 0, 0);
    queueFli(8, 1);
    repeat (8) queueInst(OP_FADD, 8, 8, 8, 0, 0);
    runStream("alu forwarding");

    // test 4 with FMADD dependents on x, y and z and independent followers
    queueFli(1, 3);
    queueFli(2, 4);
    queueFli(3, 5);
    queueInst(OP_FMADD, 10, 1, 2, 3, 0);
    queueInst(OP_FADD, 11, 10, 1, 0, 0);
    queueInst(OP_FMADD, 12, 2, 3, 1, 0);
    queueInst(OP_FSUB, 13, 1, 12, 0, 0);
    queueInst(OP_FMADD, 14, 1, 1, 2, 0);
    queueInst(OP_FMADD, 15, 2, 3, 14, 0);
    queueInst(OP_FMADD, 16, 3, 3, 3, 0);
    queueFli(17, -9);
    queueInst(OP_FADD, 18, 1, 2, 0, 0);
    queueInst(OP_FMADD, 19, 15, 14, 13, 0);
    queueInst(OP_FMIN, 19, 19, 11, 0, 0);
    runStream("fmadd stall");

    // test 5 with consumers at distance two and FMADD chains reusing operands
    queueInst(OP_FMADD, 20, 1, 2, 3, 0);
    queueFli(21, 100);
    queueInst(OP_FADD, 22, 20, 20, 0, 0);
    queueInst(OP_FMADD, 23, 20, 20, 20, 0);
    queueInst(OP_FSUB, 24, 2, 1, 0, 0);
    queueInst(OP_FMADD, 23, 23, 1, 23, 0);
    queueInst(OP_FMADD, 25, 23, 23, 22, 0);
    queueInst(OP_FMIN, 26, 25, 24, 0, 0);
    queueInst(OP_FMADD, 27, 26, 25, 26, 0);
    runStream("fmadd chains");

    // test 6 with a random stream over eight registers to crowd the hazards
    for (int k = 0; k < RandLen; k++) begin
      opIdx = int'(lfsrBits(3)) % 5;
      case (opIdx)
        0:       op = OP_FLI;
        1:       op = OP_FADD;
        2:       op = OP_FSUB;
        3:       op = OP_FMIN;
        default: op = OP_FMADD;
      endcase
      queueInst(op, int'(lfsrBits(3)), int'(lfsrBits(3)), int'(lfsrBits(3)),
                int'(lfsrBits(3)), int'(lfsrBits(16)));
    end
    runStream("random stream");

    $display("%0d tests, %0d checks, %0d errors", testNum, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== verif/fpuClockGen.sv ====
// clock source for the FPU pipeline testbench
//   free-running clock, 20 ns period
`timescale 1ns/1ns

module fpuClockGen (
  output logic clk
);

  initial clk = 1'b0;
  always #10 clk = ~clk;   // half of the 20 ns period

endmodule

// ==== verilog/fpuPipe.sv ====
// FPU pipeline slice top level
//   operand decode and the decode/execute register with bubble insert
//   execute/memory and memory/writeback registers
//   memory-stage FMADD completion and result select
//   register file, hazard unit and execute stage instances
`timescale 1ns/1ns

module fpuPipe (
  input  logic                clk,
  input  logic                rstN,
  input  logic                instValid,   // inst is presented
  input  fpuStagePkg::fpInstT inst,
  output logic                stallD,      // source holds inst while high
  output logic                wbValid,
  output fpuStagePkg::fpWbT   wb
);

  import fpuTypesPkg::*;
  import fpuStagePkg::*;

  // decode
  logic   xEnD, yEnD, zEnD;   // sources read by the decode instruction
  logic   regWriteD;
  resSelT resSelD;
  fpDataT rd1D, rd2D, rd3D;
  decExT  deN, deQ;

  // execute
  fwdSelT forwardXE, forwardYE, forwardZE;
  logic   regWriteE;
  exMemT  emN, emQ;

  // memory
  logic   regWriteM;
  fpDataT resM;
  memWbT  mwN, mwQ;

  // writeback
  logic   regWriteW;

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    xEnD      = 1'b0;
    yEnD      = 1'b0;
    zEnD      = 1'b0;
    regWriteD = 1'b0;
    resSelD   = RES_ALU;
    if (instValid) begin  // hazards only for a presented inst
      regWriteD = 1'b1;   // every op writes rd
      case (inst.op)
        OP_FADD, OP_FSUB, OP_FMIN: begin
          xEnD = 1'b1;
          yEnD = 1'b1;
        end
        OP_FMADD: begin
          xEnD    = 1'b1;
          yEnD    = 1'b1;
          zEnD    = 1'b1;
          resSelD = RES_MUL;  // sum formed in memory
        end
        default: ;            // FLI has no sources
      endcase
    end
  end

  fpuRegFile fpuRegFile_inst (
    .clk   (clk),
    .rstN  (rstN),
    .rs1   (inst.rs1),
    .rs2   (inst.rs2),
    .rs3   (inst.rs3),
    .we    (regWriteW),
    .wAdr  (mwQ.rd),
    .wData (mwQ.result),
    .rd1   (rd1D),
    .rd2   (rd2D),
    .rd3   (rd3D)
  );

  always_comb begin
    deN.valid    = instValid & ~stallD;   // stall turns into a bubble
    deN.op       = inst.op;
    deN.rd       = inst.rd;
    deN.regWrite = regWriteD;
    deN.resSel   = resSelD;
    deN.adr1     = inst.rs1;
    deN.adr2     = inst.rs2;
    deN.adr3     = inst.rs3;
    deN.rData1   = rd1D;
    deN.rData2   = rd2D;
    deN.rData3   = rd3D;
    deN.imm      = inst.imm;
  end

  ////////////////////////////////////////////////////////////////////////////
  // hazards and execute
  ////////////////////////////////////////////////////////////////////////////

  assign regWriteE = deQ.valid & deQ.regWrite;  // bubbles never match
  assign regWriteM = emQ.valid & emQ.regWrite;
  assign regWriteW = mwQ.valid & mwQ.regWrite;

  fpuHazard fpuHazard_inst (
    .adr1D     (inst.rs1),
    .adr2D     (inst.rs2),
    .adr3D     (inst.rs3),
    .xEnD      (xEnD),
    .yEnD      (yEnD),
    .zEnD      (zEnD),
    .adr1E     (deQ.adr1),
    .adr2E     (deQ.adr2),
    .adr3E     (deQ.adr3),
    .rdE       (deQ.rd),
    .regWriteE (regWriteE),
    .resSelE   (deQ.resSel),
    .rdM       (emQ.rd),
    .regWriteM (regWriteM),
    .resSelM   (emQ.resSel),
    .rdW       (mwQ.rd),
    .regWriteW (regWriteW),
    .stallD    (stallD),
    .forwardXE (forwardXE),
    .forwardYE (forwardYE),
    .forwardZE (forwardZE)
  );

  fpuExecute fpuExecute_inst (
    .de        (deQ),
    .forwardXE (forwardXE),
    .forwardYE (forwardYE),
    .forwardZE (forwardZE),
    .resM      (resM),
    .resW      (mwQ.result),
    .em        (emN)
  );

  ////////////////////////////////////////////////////////////////////////////
  // memory and writeback
  ////////////////////////////////////////////////////////////////////////////

  // second half of FMADD and the stage result select
  assign resM = (emQ.resSel == RES_MUL) ? emQ.prod + emQ.addend : emQ.aluRes;

  always_comb begin
    mwN.valid    = emQ.valid;
    mwN.rd       = emQ.rd;
    mwN.regWrite = emQ.regWrite;
    mwN.result   = resM;
  end

  assign wbValid = regWriteW;    // one cycle per retirement
  assign wb.rd   = mwQ.rd;
  assign wb.data = mwQ.result;

  // stage registers where reset clears only the valid bits
  always_ff @(posedge clk) begin
    deQ <= deN;
    emQ <= emN;
    mwQ <= mwN;
    if (!rstN) begin
      deQ.valid <= 1'b0;
      emQ.valid <= 1'b0;
      mwQ.valid <= 1'b0;
    end
  end

  // the source keeps the stalled instruction in place
  assert property (@(posedge clk) disable iff (!rstN)
                   stallD |=> instValid && $stable(inst))
    else $error("stalled decode instruction changed");

  // FMADD moves on to memory so the dependent waits one cycle only
  assert property (@(posedge clk) disable iff (!rstN) stallD |=> !stallD)
    else $error("decode stalled for more than one cycle");

  // the stall keeps every execute source off an FMADD sum still in memory
  assert property (@(posedge clk) disable iff (!rstN)
                   (regWriteE && regWriteM && (emQ.resSel == RES_MUL)) |->
                   !((deQ.op != OP_FLI) && ((deQ.adr1 == emQ.rd) || (deQ.adr2 == emQ.rd))) &&
                   !((deQ.op == OP_FMADD) && (deQ.adr3 == emQ.rd)))
    else $error("execute source needs an FMADD result still in memory");

endmodule

// ==== verilog/fpuExecute.sv ====
// FPU execute stage
//   operand forwarding muxes for x, y and z
//   ALU for FLI, FADD, FSUB and FMIN
//   first half of FMADD, the product and the addend
`timescale 1ns/1ns

module fpuExecute (
  input  fpuStagePkg::decExT  de,
  input  fpuTypesPkg::fwdSelT forwardXE,
  input  fpuTypesPkg::fwdSelT forwardYE,
  input  fpuTypesPkg::fwdSelT forwardZE,
  input  fpuTypesPkg::fpDataT resM,    // memory-stage result
  input  fpuTypesPkg::fpDataT resW,    // writeback result
  output fpuStagePkg::exMemT  em
);

  import fpuTypesPkg::*;

  fpDataT x;
  fpDataT y;
  fpDataT z;
  fpDataT immExt;   // sign-extended FLI immediate
  fpDataT aluRes;

  ////////////////////////////////////////////////////////////////////////////
  // operand select
  ////////////////////////////////////////////////////////////////////////////

  function automatic fpDataT pickOperand(input fwdSelT sel, input fpDataT regVal);
    case (sel)
      FWD_MEM: pickOperand = resM;
      FWD_WB:  pickOperand = resW;
      default: pickOperand = regVal;   // read in decode
    endcase
  endfunction

  assign x = pickOperand(forwardXE, de.rData1);
  assign y = pickOperand(forwardYE, de.rData2);
  assign z = pickOperand(forwardZE, de.rData3);

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////

  assign immExt = {{16{de.imm[15]}}, de.imm};

  always_comb begin
    case (de.op)
      OP_FLI:  aluRes = immExt;
      OP_FADD: aluRes = x + y;
      OP_FSUB: aluRes = x - y;
      OP_FMIN: aluRes = ($signed(x) < $signed(y)) ? x : y;  // signed compare
      default: aluRes = '0;        // FMADD result comes from memory
    endcase
  end

  // pass-through and multiply-add first half
  always_comb begin
    em.valid    = de.valid;
    em.rd       = de.rd;
    em.regWrite = de.regWrite;
    em.resSel   = de.resSel;
    em.aluRes   = aluRes;
    em.prod     = x * y;           // low 32 bits kept
    em.addend   = z;
  end

endmodule

// ==== verilog/fpuHazard.sv ====
// FPU hazard unit
//   decode stall when a source waits on an FMADD still in execute
//   per-operand forwarding select for the execute stage
//   ALU results forwarded from memory and late results only from writeback
`timescale 1ns/1ns

module fpuHazard (
  input  fpuTypesPkg::regAdrT adr1D, adr2D, adr3D,  // decode source addresses
  input  logic                xEnD, yEnD, zEnD,     // decode source is read
  input  fpuTypesPkg::regAdrT adr1E, adr2E, adr3E,  // execute source addresses
  input  fpuTypesPkg::regAdrT rdE,
  input  logic                regWriteE,            // valid and writing
  input  fpuTypesPkg::resSelT resSelE,
  input  fpuTypesPkg::regAdrT rdM,
  input  logic                regWriteM,
  input  fpuTypesPkg::resSelT resSelM,
  input  fpuTypesPkg::regAdrT rdW,
  input  logic                regWriteW,
  output logic                stallD,
  output fpuTypesPkg::fwdSelT forwardXE, forwardYE, forwardZE
);

  import fpuTypesPkg::*;

  logic matchDE;   // some decode source is the execute destination
  logic lateE;     // execute holds a writing FMADD

  ////////////////////////////////////////////////////////////////////////////
  // stall
  ////////////////////////////////////////////////////////////////////////////

  assign matchDE = ((adr1D == rdE) & xEnD) |
                   ((adr2D == rdE) & yEnD) |
                   ((adr3D == rdE) & zEnD);
  assign lateE   = regWriteE & (resSelE == RES_MUL);
  assign stallD  = matchDE & lateE;  // writeback forwarding covers the cycle after

  ////////////////////////////////////////////////////////////////////////////
  // forwarding
  ////////////////////////////////////////////////////////////////////////////

  // memory stage wins over writeback since it is younger
  function automatic fwdSelT pickFwd(input regAdrT adrE);
    pickFwd = FWD_NONE;
    if ((adrE == rdM) && regWriteM) begin
      if (resSelM == RES_ALU) pickFwd = FWD_MEM;  // product sum not ready for bypass yet
    end else if ((adrE == rdW) && regWriteW) begin
      pickFwd = FWD_WB;
    end
  endfunction

  assign forwardXE = pickFwd(adr1E);
  assign forwardYE = pickFwd(adr2E);
  assign forwardZE = pickFwd(adr3E);

endmodule

// ==== verilog/fpuRegFile.sv ====
// FPU register file
//   32 words, cleared by reset
//   three combinational reads, one write port
//   write-through bypass so decode sees a same-cycle writeback
`timescale 1ns/1ns

module fpuRegFile (
  input  logic               clk,
  input  logic               rstN,
  input  fpuTypesPkg::regAdrT rs1,    // x read address
  input  fpuTypesPkg::regAdrT rs2,    // y read address
  input  fpuTypesPkg::regAdrT rs3,    // z read address
  input  logic               we,      // writeback strobe
  input  fpuTypesPkg::regAdrT wAdr,
  input  fpuTypesPkg::fpDataT wData,
  output fpuTypesPkg::fpDataT rd1,
  output fpuTypesPkg::fpDataT rd2,
  output fpuTypesPkg::fpDataT rd3
);

  import fpuTypesPkg::*;

  fpDataT regs [32];

  // array value, or the word being written this cycle
  function automatic fpDataT readPort(input regAdrT adr);
    readPort = (we && (wAdr == adr)) ? wData : regs[adr];
  endfunction

  assign rd1 = readPort(rs1);
  assign rd2 = readPort(rs2);
  assign rd3 = readPort(rs3);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0; // all registers start at zero
    end else if (we) begin
      regs[wAdr] <= wData;
    end
  end

  // a retiring result has to be fully known, else X spreads into every consumer
  assert property (@(posedge clk) disable iff (!rstN) we |-> !$isunknown({wAdr, wData}))
    else $error("register file write with unknown address or data");

endmodule

// ==== verilog/fpuStagePkg.sv ====
// packed structs moving through the FPU pipeline
//   instruction word at the input
//   decode/execute, execute/memory and memory/writeback registers
//   retirement record seen from outside
package fpuStagePkg;

  import fpuTypesPkg::*;

  // instruction as presented by the source
  typedef struct packed {
    fpOpT   op;
    regAdrT rd;
    regAdrT rs1;   // x
    regAdrT rs2;   // y
    regAdrT rs3;   // z, FMADD only
    immT    imm;   // FLI only
  } fpInstT;

  ////////////////////////////////////////////////////////////////////////////
  // stage registers
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic   valid;     // cleared for a bubble
    fpOpT   op;
    regAdrT rd;
    logic   regWrite;
    resSelT resSel;
    regAdrT adr1;      // source addresses, needed by forwarding in execute
    regAdrT adr2;
    regAdrT adr3;
    fpDataT rData1;    // register file reads taken in decode
    fpDataT rData2;
    fpDataT rData3;
    immT    imm;
  } decExT;

  typedef struct packed {
    logic   valid;
    regAdrT rd;
    logic   regWrite;
    resSelT resSel;
    fpDataT aluRes;    // final for RES_ALU
    fpDataT prod;      // x*y, low 32 bits
    fpDataT addend;    // z
  } exMemT;

  typedef struct packed {
    logic   valid;
    regAdrT rd;
    logic   regWrite;
    fpDataT result;
  } memWbT;

  // retirement, paired with wbValid
  typedef struct packed {
    regAdrT rd;
    fpDataT data;
  } fpWbT;

endpackage

// ==== verilog/fpuTypesPkg.sv ====
// scalar types shared by the FPU pipeline slice
//   data word, register address, immediate
//   opcode enum, result-select and forward-select enums
package fpuTypesPkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths with a meaning
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] fpDataT;   // two's-complement data word
  typedef logic [4:0]  regAdrT;   // 32-entry register file index
  typedef logic [15:0] immT;      // FLI immediate, sign-extended in execute

  ////////////////////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    OP_FLI   = 3'd0,  // rd = sext(imm)
    OP_FADD  = 3'd1,  // rd = x + y
    OP_FSUB  = 3'd2,  // rd = x - y
    OP_FMIN  = 3'd3,  // rd = signed min(x, y)
    OP_FMADD = 3'd4   // rd = x*y + z, late result
  } fpOpT;

  // where the result of an instruction gets formed
  typedef enum logic [1:0] {
    RES_ALU = 2'b00,  // ready leaving execute
    RES_MUL = 2'b01   // finished in memory by the adder
  } resSelT;

  // execute operand source
  typedef enum logic [1:0] {
    FWD_NONE = 2'b00, // register file value latched in decode
    FWD_WB   = 2'b01, // writeback result
    FWD_MEM  = 2'b10  // memory-stage result
  } fwdSelT;

endpackage
